// File: files.f
+incdir+hdl
hdl/mmioPkg.sv
hdl/emifBusFsm.sv
hdl/mmioRegFile.sv
hdl/mmioReadMux.sv
hdl/mmioClient.sv
verification/mmioClientTb.sv

// File: hdl/emifBusFsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module emifBusFsm (
  input  logic                shlClk,
  input  logic                rstN,
  input  mmioPkg::busPinsT    bus,
  input  logic [`MMIO_DW-1:0] wrData,
  output mmioPkg::regReqT     req
);

  typedef enum logic [1:0] {
    stIdle    = 2'd0,  // Waiting for an address strobe
    stAccess  = 2'd1,  // Address held, strobe expected
    stWaitRel = 2'd2,  // Pulse done, waiting for strobes high
    stAborted = 2'd3   // Chip select dropped mid-access
  } stateT;

  stateT               state;
  stateT               stateNext;
  logic [`MMIO_AW-1:0] offsetQ;      // Latched window offset
  logic                inWindowQ;    // Latched window flag
  logic                addrHit;      // Valid address phase
  logic                wrHit;
  logic                rdHit;
  logic                strobesIdle;

  // ------------------------------
  // Strobe decode
  // ------------------------------
  assign addrHit     = (state == stIdle) && !bus.adsN && !bus.csN;
  assign strobesIdle = bus.weN && bus.oeN;

  // Write wins when both strobes are low
  assign wrHit = (state == stAccess) && !bus.csN && !bus.weN;
  assign rdHit = (state == stAccess) && !bus.csN && bus.weN && !bus.oeN;

  always_comb
  begin
    stateNext = state;
    case (state)
      stIdle:    if (addrHit) stateNext = stAccess;
      stAccess:
      begin
        if (bus.csN)
          stateNext = stAborted;   // Host gave up, no pulse
        else if (wrHit || rdHit)
          stateNext = stWaitRel;
      end
      stWaitRel: if (strobesIdle) stateNext = stIdle;
      // Also wait for the address strobe before rearming
      stAborted: if (strobesIdle && bus.adsN) stateNext = stIdle;
      default:   stateNext = stIdle;
    endcase
  end

  always_ff @(posedge shlClk)
  begin
    if (!rstN)
    begin
      state     <= stIdle;
      inWindowQ <= 1'b0;
    end
    else
    begin
      state <= stateNext;
      if (addrHit)
        inWindowQ <= !bus.addr[`MMIO_AW];  // Bit 7 clear means lower window
    end
  end

  // Window offset of the current access
  always_ff @(posedge shlClk)
  begin
    if (addrHit)
      offsetQ <= bus.addr[`MMIO_AW-1:0];
  end

  // Upper-window writes never reach the register file
  assign req.wrEn      = wrHit && inWindowQ;
  assign req.rdCapture = rdHit;              // Mux zeroes upper reads
  assign req.inWindow  = inWindowQ;
  assign req.offset    = offsetQ;
  assign req.wrData    = wrData;

  // ------------------------------
  // Checks
  // ------------------------------
  aExclusive: assert property (@(posedge shlClk) disable iff (!rstN)
    !(req.wrEn && req.rdCapture))
    else $error("wrEn and rdCapture high together");

  // Exactly one pulse, followed by the release wait
  aOnePulse: assert property (@(posedge shlClk) disable iff (!rstN)
    (req.wrEn || req.rdCapture) |=> (state == stWaitRel) && !(req.wrEn || req.rdCapture))
    else $error("Second pulse or bad state after an access pulse");

endmodule

`default_nettype wire

// File: hdl/mmioClient.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmioClient (
  // Shell clock, bus is sampled here too
  input  logic                shlClk,
  input  logic                rstN,

  // Board controller bus
  input  mmioPkg::busPinsT    bus,
  input  logic [`MMIO_DW-1:0] wrData,
  output logic [`MMIO_DW-1:0] rdData,

  // Status inputs for the read-only overlay
  input  mmioPkg::phyStatusT  phyStatus,
  input  logic [15:0]         fromRole,
  input  logic [31:0]         fromSmc,

  // Control outputs to the fabric
  output mmioPkg::eth0TuneT   eth0Tune,
  output mmioPkg::diagCtrlT   diagCtrl,
  output mmioPkg::nts0CfgT    nts0Cfg,
  output logic [15:0]         toRole,
  output logic [31:0]         toSmc
);

  // ------------------------------
  // Internal wiring
  // ------------------------------
  mmioPkg::regReqT   req;    // Decided access from the bus FSM
  mmioPkg::regArrayT regs;   // Whole window to the read mux

  // Strobes to single pulses
  emifBusFsm uBusFsm (
    .shlClk (shlClk),
    .rstN   (rstN),
    .bus    (bus),
    .wrData (wrData),
    .req    (req)
  );

  // Storage and field decode
  mmioRegFile uRegFile (
    .shlClk   (shlClk),
    .rstN     (rstN),
    .req      (req),
    .regs     (regs),
    .eth0Tune (eth0Tune),
    .diagCtrl (diagCtrl),
    .nts0Cfg  (nts0Cfg),
    .toRole   (toRole),
    .toSmc    (toSmc)
  );

  // Overlay and registered read data
  mmioReadMux uReadMux (
    .shlClk    (shlClk),
    .rstN      (rstN),
    .req       (req),
    .regs      (regs),
    .phyStatus (phyStatus),
    .fromRole  (fromRole),
    .fromSmc   (fromSmc),
    .rdData    (rdData)
  );

endmodule

`default_nettype wire

// File: hdl/mmioPkg.sv
`default_nettype none

`include "mmio_defines.svh"

package mmioPkg;

  // Whole lower window, byte 0 at the bottom
  typedef logic [`MMIO_NREGS-1:0][`MMIO_DW-1:0] regArrayT;

  // ------------------------------
  // Bus side
  // ------------------------------

  // Raw strobes from the board controller, all active low
  typedef struct packed {
    logic                csN;    // Chip select
    logic                weN;    // Write enable
    logic                adsN;   // Address strobe
    logic                oeN;    // Output enable
    logic [`MMIO_DW-1:0] addr;   // Bit 7 picks the upper window
  } busPinsT;

  // One decided access, pulses last a single cycle
  typedef struct packed {
    logic                wrEn;       // Already gated by the window flag
    logic                rdCapture;  // Load strobe for the read register
    logic                inWindow;   // Address bit 7 was clear
    logic [`MMIO_AW-1:0] offset;
    logic [`MMIO_DW-1:0] wrData;
  } regReqT;

  // ------------------------------
  // Fabric side
  // ------------------------------

  typedef struct packed {
    logic       rxEqualizerMode;
    logic [3:0] txDriverSwing;
    logic [4:0] txPreCursor;
    logic [4:0] txPostCursor;
  } eth0TuneT;

  typedef struct packed {
    logic pcsLoopbackEn;
    logic macLoopbackEn;
    logic macAddrSwapEn;
  } diagCtrlT;

  typedef struct packed {
    logic [47:0] macAddress;
    logic [31:0] ipAddress;
  } nts0CfgT;

  // Listed MSB first so mc0 lands in bit 0
  typedef struct packed {
    logic qpllLock;
    logic coreReady;
    logic mc1InitCalComplete;
    logic mc0InitCalComplete;
  } phyStatusT;

endpackage

`default_nettype wire

// File: hdl/mmioReadMux.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmioReadMux (
  input  logic                shlClk,
  input  logic                rstN,
  input  mmioPkg::regReqT     req,
  input  mmioPkg::regArrayT   regs,
  input  mmioPkg::phyStatusT  phyStatus,
  input  logic [15:0]         fromRole,
  input  logic [31:0]         fromSmc,
  output logic [`MMIO_DW-1:0] rdData
);

  logic [`MMIO_DW-1:0] selByte;   // Byte at the latched offset

  // ------------------------------
  // Selection with status overlay
  // ------------------------------
  always_comb
  begin
    selByte = regs[req.offset];   // Stored byte by default
    case (req.offset)
      // Four flags in the low nibble
      `REG_PHY_STAT:               selByte = {4'b0000, phyStatus};

      // Live ROLE word, highest byte at highest offset
      `REG_FROM_ROLE0:             selByte = fromRole[7:0];
      `REG_FROM_ROLE0 + 7'd1:      selByte = fromRole[15:8];

      // Live SMC word
      `REG_FROM_SMC0:              selByte = fromSmc[7:0];
      `REG_FROM_SMC0 + 7'd1:       selByte = fromSmc[15:8];
      `REG_FROM_SMC0 + 7'd2:       selByte = fromSmc[23:16];
      `REG_FROM_SMC0 + 7'd3:       selByte = fromSmc[31:24];
      default:                     selByte = regs[req.offset];
    endcase
  end

  // ------------------------------
  // Read data register
  // ------------------------------

  // Held between captures, upper window reads as zero
  always_ff @(posedge shlClk)
  begin
    if (!rstN)
      rdData <= '0;
    else if (req.rdCapture)
      rdData <= req.inWindow ? selByte : '0;
  end

  // Only a capture or reset may move the bus data
  aHoldData: assert property (@(posedge shlClk) disable iff (!rstN)
    $past(rstN) && !$stable(rdData) |-> $past(req.rdCapture))
    else $error("rdData changed without a read capture");

endmodule

`default_nettype wire

// File: hdl/mmioRegFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmio_defines.svh"

module mmioRegFile (
  input  logic              shlClk,
  input  logic              rstN,
  input  mmioPkg::regReqT   req,
  output mmioPkg::regArrayT regs,
  output mmioPkg::eth0TuneT eth0Tune,
  output mmioPkg::diagCtrlT diagCtrl,
  output mmioPkg::nts0CfgT  nts0Cfg,
  output logic [15:0]       toRole,
  output logic [31:0]       toSmc
);

  // ------------------------------
  // Reset image
  // ------------------------------
  function automatic mmioPkg::regArrayT resetImage();
    mmioPkg::regArrayT img;
    img = '0;                                   // Unlisted bytes clear

    // Product data
    img[`REG_VPD_ID]                 = `RST_REG_00;
    img[`REG_VPD_VER]                = `RST_REG_01;
    img[7'h03]                       = `RST_REG_03;

    // ETH0 tuning triplet
    img[`REG_PHY_ETH0]               = `RST_REG_11;
    img[`REG_PHY_ETH0 + 7'd1]        = `RST_REG_12;
    img[`REG_PHY_ETH0 + 7'd2]        = `RST_REG_13;

    // ROLE pattern bytes
    img[7'h4E]                       = `RST_REG_4E;
    img[7'h4F]                       = `RST_REG_4F;

    // Scratch
    img[`REG_DIAG_SCRATCH0]          = `RST_REG_70;
    img[`REG_DIAG_SCRATCH0 + 7'd1]   = `RST_REG_71;
    img[`REG_DIAG_SCRATCH0 + 7'd2]   = `RST_REG_72;
    img[`REG_DIAG_SCRATCH0 + 7'd3]   = `RST_REG_73;
    return img;
  endfunction

  localparam mmioPkg::regArrayT cResetImage = resetImage();

  // ------------------------------
  // Storage
  // ------------------------------

  // Every byte is writable, the read-only overlay lives in the mux
  always_ff @(posedge shlClk)
  begin
    if (!rstN)
      regs <= cResetImage;
    else if (req.wrEn)
      regs[req.offset] <= req.wrData;
  end

  // ------------------------------
  // Control field decode
  // ------------------------------

  // ETH0 transceiver tuning
  assign eth0Tune.rxEqualizerMode = regs[`REG_PHY_ETH0][0];
  assign eth0Tune.txDriverSwing   = regs[`REG_PHY_ETH0][7:4];
  assign eth0Tune.txPreCursor     = regs[`REG_PHY_ETH0 + 7'd1][4:0];
  assign eth0Tune.txPostCursor    = regs[`REG_PHY_ETH0 + 7'd2][4:0];

  // Loopback and swap enables, upper bits unused
  assign diagCtrl.pcsLoopbackEn = regs[`REG_DIAG_CTRL][0];
  assign diagCtrl.macLoopbackEn = regs[`REG_DIAG_CTRL][1];
  assign diagCtrl.macAddrSwapEn = regs[`REG_DIAG_CTRL][2];

  // Multi-byte words, highest offset is the MSB
  assign nts0Cfg.macAddress = regs[`REG_LY2_MAC0 + 7'd5 : `REG_LY2_MAC0];
  assign nts0Cfg.ipAddress  = regs[`REG_LY3_IP0 + 7'd3 : `REG_LY3_IP0];

  assign toRole = regs[`REG_TO_ROLE0 + 7'd1 : `REG_TO_ROLE0];  // ROLE command word
  assign toSmc  = regs[`REG_TO_SMC0 + 7'd3 : `REG_TO_SMC0];    // SMC command word

  // ------------------------------
  // Checks
  // ------------------------------

  // The bus FSM owns window gating
  aLowerOnly: assert property (@(posedge shlClk) disable iff (!rstN)
    req.wrEn |-> req.inWindow)
    else $error("Register write outside the lower window");

endmodule

`default_nettype wire

// File: hdl/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// ------------------------------
// Bus and window geometry
// ------------------------------
`define MMIO_DW     8     // Data bus width
`define MMIO_AW     7     // Offset width, lower window only
`define MMIO_NREGS  128   // Bytes in the register window

// ------------------------------
// Register offsets
// ------------------------------

// Virtual product data
`define REG_VPD_ID         7'h00
`define REG_VPD_VER        7'h01
`define REG_VPD_REV        7'h02

// Physical interfaces
`define REG_PHY_STAT       7'h10   // Read-only status overlay
`define REG_PHY_ETH0       7'h11   // Three tuning bytes

// Layer-2 and layer-3 addressing, lowest byte first
`define REG_LY2_MAC0       7'h22   // Six bytes
`define REG_LY3_IP0        7'h34   // Four bytes

// ROLE and SMC exchange words
`define REG_FROM_ROLE0     7'h40   // Two bytes, read-only
`define REG_TO_ROLE0       7'h42   // Two bytes
`define REG_FROM_SMC0      7'h44   // Four bytes, read-only
`define REG_TO_SMC0        7'h48   // Four bytes

// Diagnostics
`define REG_DIAG_SCRATCH0  7'h70   // Four scratch bytes
`define REG_DIAG_CTRL      7'h74   // Loopback and swap enables

// Page selector held as plain storage
`define REG_PAGE_SEL       7'h7F

// ------------------------------
// Non-zero reset values
// ------------------------------
`define RST_REG_00  8'h3C   // Product ID
`define RST_REG_01  8'h01   // Version
`define RST_REG_03  8'h33

// ETH0 tuning, equalizer on, swing 4, cursors 5
`define RST_REG_11  8'h41
`define RST_REG_12  8'h05
`define RST_REG_13  8'h05

// ROLE pattern bytes above the TO_SMC word
`define RST_REG_4E  8'h13
`define RST_REG_4F  8'h37

// Scratch pattern
`define RST_REG_70  8'hDE
`define RST_REG_71  8'hAD
`define RST_REG_72  8'hBE
`define RST_REG_73  8'hEF

`endif

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module mmioClientTb -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 || { echo "Build or simulation aborted, see build.log and sim.log"; exit 1; }
grep -q 'Test failures found' sim.log && { echo "Simulation FAILED"; exit 1; } || { echo "Simulation PASSED"; exit 0; }

// File: verification/mmioClientTb.sv
`timescale 1ns/1ps
`default_nettype none

module mmioClientTb;

  localparam string cStimFile = "verification/mmioClient_stim.txt";

  logic               shlClk = 1'b0;
  logic               rstN;
  mmioPkg::busPinsT   bus;
  logic [7:0]         wrData;
  logic [7:0]         rdData;
  mmioPkg::phyStatusT phyStatus;
  logic [15:0]        fromRole;
  logic [31:0]        fromSmc;
  mmioPkg::eth0TuneT  eth0Tune;
  mmioPkg::diagCtrlT  diagCtrl;
  mmioPkg::nts0CfgT   nts0Cfg;
  logic [15:0]        toRole;
  logic [31:0]        toSmc;

  string  stimLines[$];        // Operation lines only
  string  testName = "";
  int     testErrs = 0;
  int     errCount = 0;
  int     testCount = 0;
  int     failedTests = 0;
  int     checkCount = 0;
  longint watchdogNs = 0;      // Armed once the stim file is loaded

  mmioClient DUT (.*);

  always #50 shlClk = ~shlClk;   // 100 ns period

  task automatic checkValue(input logic [63:0] got, input logic [63:0] exp, input string what);
    checkCount++;
    if (got !== exp)
    begin
      $display("ERR @%0t ns: %s got %0h, expected %0h", $time, what, got, exp);
      errCount++;
      testErrs++;
    end
  endtask

  // Bad or unknown stim content
  task automatic reportStimError(input string msg);
    $display("%s", msg);
    errCount++;
    testErrs++;
  endtask

  // ------------------------------
  // Bus accesses, four edges each
  // ------------------------------
  task automatic busWrite(input logic [7:0] addr, input logic [7:0] data, input logic csHigh);
    @(posedge shlClk) #5;
    bus.csN  = csHigh;            // High means the FSM never sees it
    bus.adsN = 1'b0;
    bus.addr = addr;
    @(posedge shlClk) #5;         // Address latched
    bus.adsN = 1'b1;
    bus.weN  = 1'b0;
    wrData   = data;
    @(posedge shlClk) #5;         // Write pulse edge
    bus.weN  = 1'b1;
    bus.csN  = 1'b1;
    @(posedge shlClk) #5;         // FSM back in idle
  endtask

  task automatic busRead(input logic [7:0] addr, output logic [7:0] data);
    @(posedge shlClk) #5;
    bus.csN  = 1'b0;
    bus.adsN = 1'b0;
    bus.addr = addr;
    @(posedge shlClk) #5;
    bus.adsN = 1'b1;
    bus.oeN  = 1'b0;
    @(posedge shlClk) #5;         // Capture edge has passed
    data     = rdData;
    bus.oeN  = 1'b1;
    bus.csN  = 1'b1;
    @(posedge shlClk) #5;
  endtask

  // One summary line per finished test
  task automatic closeTest();
    if (testName != "")
    begin
      testCount++;
      if (testErrs == 0)
        $display("Test %-16s ok", testName);
      else
      begin
        failedTests++;
        $display("Test %-16s FAILED with %0d errors", testName, testErrs);
      end
    end
    testErrs = 0;
  endtask

  task automatic runLine(input string line, input int opNo);
    byte         opc;
    logic [7:0]  addr;
    logic [7:0]  data;
    logic [7:0]  got;
    logic [3:0]  flags;
    logic [15:0] role;
    logic [31:0] smc;
    logic [63:0] value;
    logic [63:0] outVal;
    string       name;
    bit          known;
    int          n;
    opc = line[0];
    case (opc)
      "T":
      begin
        closeTest();
        testName = line.substr(2, line.len() - 1);
      end
      "W", "C":
      begin
        n = $sscanf(line, "%c %h %h", opc, addr, data);
        if (n == 3)
          busWrite(addr, data, opc == "C");
        else
          reportStimError($sformatf("Stim operation %0d is malformed: %s", opNo, line));
      end
      "R":
      begin
        n = $sscanf(line, "%c %h %h", opc, addr, data);
        if (n == 3)
        begin
          busRead(addr, got);
          checkValue(64'(got), 64'(data), $sformatf("read %02h", addr));
        end
        else
          reportStimError($sformatf("Stim operation %0d is malformed: %s", opNo, line));
      end
      "S":
      begin
        n = $sscanf(line, "%c %h %h %h", opc, flags, role, smc);
        if (n == 4)
        begin
          @(posedge shlClk) #5;
          phyStatus = flags;      // mc0 in bit 0
          fromRole  = role;
          fromSmc   = smc;
        end
        else
          reportStimError($sformatf("Stim operation %0d is malformed: %s", opNo, line));
      end
      "O":
      begin
        n = $sscanf(line, "%c %s %h", opc, name, value);
        known = 1'b1;
        if (name == "tune")
          outVal = 64'(eth0Tune);
        else if (name == "diag")
          outVal = 64'(diagCtrl);
        else if (name == "mac")
          outVal = 64'(nts0Cfg.macAddress);
        else if (name == "ip")
          outVal = 64'(nts0Cfg.ipAddress);
        else if (name == "toRole")
          outVal = 64'(toRole);
        else if (name == "toSmc")
          outVal = 64'(toSmc);
        else
          known = 1'b0;
        if (n != 3)
          reportStimError($sformatf("Stim operation %0d is malformed: %s", opNo, line));
        else if (known)
          checkValue(outVal, value, {"output ", name});
        else
          reportStimError($sformatf("Stim operation %0d names an unknown output %s",
                                    opNo, name));
      end
      default:
        reportStimError($sformatf("Stim operation %0d has an unknown opcode '%c'", opNo, opc));
    endcase
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    int    fd;
    string line;
    rstN      = 1'b0;
    bus       = '{csN: 1'b1, weN: 1'b1, adsN: 1'b1, oeN: 1'b1, addr: 8'h00};
    wrData    = '0;
    phyStatus = '0;
    fromRole  = '0;
    fromSmc   = '0;
    fd = $fopen(cStimFile, "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file %s", cStimFile);
      $display("Test failures found");
      $finish;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) > 0)
        begin
          // Drop line endings, skip comments and blank lines
          while (line.len() > 0 &&
                 (line[line.len() - 1] == 8'h0A || line[line.len() - 1] == 8'h0D))
            line = line.substr(0, line.len() - 2);
          if (line.len() > 0 && line[0] != "#")
            stimLines.push_back(line);
        end
      end
      $fclose(fd);
      watchdogNs = longint'(stimLines.size()) * 64'd600 + 64'd10000;
      repeat (5) @(posedge shlClk);
      #5 rstN = 1'b1;
      foreach (stimLines[i])
        runLine(stimLines[i], i + 1);
      closeTest();
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               testCount, failedTests, checkCount, errCount);
      if (errCount == 0)
        $display("All tests passed!");
      else
        $display("Test failures found");
      $finish;
    end
  end

  // Six cycles per operation plus slack for reset
  initial
  begin
    wait (watchdogNs != 0);
    #(watchdogNs);
    $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/mmioClient_stim.txt
# W/C addr data | R addr expected | S flags fromRole fromSmc
# O output expected | T test name | all values in hex, C writes with csN high
T reset_values
R 00 3C
R 70 DE
R 73 EF
R 4E 13
R 4F 37
R 05 00
O tune 50A5
T readback
W 7F 5A
W 71 01
R 7F 5A
R 71 01
T status_overlay
S 0B BEEF 01234567
W 10 FF
W 40 55
R 10 0B
R 40 EF
R 41 BE
R 47 01
S 04 1234 89ABCDEF
R 10 04
T control_outputs
W 11 90
W 12 FF
O tune 27E5
W 74 F9
O diag 4
W 22 11
W 27 66
O mac 660000000011
W 34 0A
O ip 0000000A
W 43 AB
O toRole AB00
W 4B 12
O toSmc 12000000
T blocked_writes
W 85 77
R 05 00
C 01 99
R 01 01
R 80 00
